/* design/pit_pkg.sv */
// shared definitions for the three channel interval timer
package pit_pkg;

	// ========================================
	// sizes and address map
	// ========================================
	localparam int NUM_CHAN = 3;
	localparam int DATA_W   = 32;
	localparam int ADR_W    = 6;
	// one byte select per data byte
	localparam int SEL_W    = DATA_W / 8;
	// adr[5:4] picks the channel, adr[3:2] the register
	localparam int CHAN_LSB = 4;
	localparam int REG_LSB  = 2;

	// register select codes
	localparam logic [1:0] REG_COUNT = 2'd0;
	localparam logic [1:0] REG_MAX   = 2'd1;
	localparam logic [1:0] REG_ONT   = 2'd2;
	localparam logic [1:0] REG_CTRL  = 2'd3;

	// ========================================
	// types
	// ========================================
	// bus request as seen at the slave port
	typedef struct packed {
		logic              cs;
		logic              cyc;
		logic              stb;
		logic              we;
		logic [SEL_W-1:0]  sel;
		logic [ADR_W-1:0]  adr;
		logic [DATA_W-1:0] dat;
	} pit_bus_req_t;

	// per channel control bits, ld lands in bit 0
	typedef struct packed {
		logic ge;
		logic xc;
		logic ar;
		logic ce;
		logic ld;
	} pit_ctrl_t;

	// one byte lane of the control word
	typedef struct packed {
		logic [2:0] pad;
		pit_ctrl_t  ctrl;
	} pit_ctrl_byte_t;

	// control word, seen as raw data or as byte lanes (lane 3 unused)
	typedef union packed {
		logic [DATA_W-1:0]               raw;
		pit_ctrl_byte_t [SEL_W-1:0]      lane;
	} pit_ctrl_word_u;

	// write strobes into one channel
	typedef struct packed {
		logic wr_max;
		logic wr_ont;
		logic wr_ctrl;
	} pit_chan_wr_t;

	// channel state returned for readback
	typedef struct packed {
		logic [DATA_W-1:0] count;
		logic [DATA_W-1:0] maxcount;
		logic [DATA_W-1:0] ontime;
		pit_ctrl_t         ctrl;
	} pit_chan_stat_t;

endpackage

/* design/pit_edge_det.sv */
// synchronizer plus rising edge detect for an external clock pin
module pit_edge_det (
	input  logic clk_i,
	input  logic rst_i,
	input  logic sig_i,
	output logic rise_o
);

	// two stage sync, then one more flop for the previous sample
	logic sync_1;
	logic sync_2;
	logic prev;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			prev   <= 1'b0;
		end else begin
			sync_1 <= sig_i;
			sync_2 <= sync_1;
			prev   <= sync_2;
		end
	end

	// single cycle pulse on a low to high transition
	assign rise_o = sync_2 & ~prev;

endmodule

/* design/pit_channel.sv */
// one timer channel: registers, down counter and out pin
module pit_channel (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  pit_pkg::pit_chan_wr_t       wr_i,
	input  logic [pit_pkg::DATA_W-1:0]  wdat_i,
	input  pit_pkg::pit_ctrl_t          ctrl_i,
	input  logic                        ext_clk_i,
	input  logic                        gate_i,
	output logic                        out_o,
	output pit_pkg::pit_chan_stat_t     stat_o
);

	// ========================================
	// state
	// ========================================
	logic [pit_pkg::DATA_W-1:0] maxcount;
	logic [pit_pkg::DATA_W-1:0] ontime;
	logic [pit_pkg::DATA_W-1:0] count;
	logic [pit_pkg::DATA_W-1:0] count_dec;
	pit_pkg::pit_ctrl_t         ctrl_q;
	logic                       out_q;

	// count engine terms
	logic ext_rise;
	logic cnt_en;
	logic at_tc;
	logic hit_ont;

	// external count source, two cycles of sync latency
	pit_edge_det u_edge_det (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.sig_i  (ext_clk_i),
		.rise_o (ext_rise)
	);

	// ========================================
	// count qualify
	// ========================================
	// ce must be set; xc waits for an ext edge, ge waits for the gate
	assign cnt_en = ctrl_q.ce
		& (~ctrl_q.xc | ext_rise)
		& (~ctrl_q.ge | gate_i);

	// terminal count
	assign at_tc = (count == '0);
	assign count_dec = count - 1'b1;
	// out goes high together with count reaching ontime
	assign hit_ont = (count_dec == ontime);

	// ========================================
	// registers written from the bus
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			maxcount <= '0;
			ontime   <= '0;
		end else begin
			if (wr_i.wr_max)
				maxcount <= wdat_i;
			if (wr_i.wr_ont)
				ontime <= wdat_i;
		end
	end

	// control bits
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_q.ld <= 1'b0;
			ctrl_q.ce <= 1'b0;
			// auto reload is the default after reset
			ctrl_q.ar <= 1'b1;
			ctrl_q.xc <= 1'b0;
			ctrl_q.ge <= 1'b0;
		end else if (wr_i.wr_ctrl) begin
			ctrl_q <= ctrl_i;
		end else begin
			// load is a one cycle request
			ctrl_q.ld <= 1'b0;
			// one-shot mode stops itself at terminal count
			if (!ctrl_q.ld && cnt_en && at_tc && !ctrl_q.ar)
				ctrl_q.ce <= 1'b0;
		end
	end

	// ========================================
	// down counter
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count <= '0;
		end else if (ctrl_q.ld) begin
			count <= maxcount;
		end else if (cnt_en) begin
			if (at_tc) begin
				// reload, or hold at 0 when stopping
				if (ctrl_q.ar)
					count <= maxcount;
			end else begin
				count <= count_dec;
			end
		end
	end

	// out pin: high from ontime down through 0
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_q <= 1'b0;
		end else if (ctrl_q.ld) begin
			// fresh load restarts the output low
			out_q <= 1'b0;
		end else if (cnt_en) begin
			if (at_tc)
				out_q <= 1'b0;
			else if (hit_ont)
				out_q <= 1'b1;
		end
	end

	assign out_o = out_q;

	// readback view
	assign stat_o.count    = count;
	assign stat_o.maxcount = maxcount;
	assign stat_o.ontime   = ontime;
	assign stat_o.ctrl     = ctrl_q;

endmodule

/* design/pit_regs.sv */
// bus slave: select, ack, write decode and readback mux
module pit_regs (
	input  logic                                               clk_i,
	input  logic                                               rst_i,
	input  pit_pkg::pit_bus_req_t                              req_i,
	output logic                                               ack_o,
	output logic [pit_pkg::DATA_W-1:0]                         dat_o,
	output pit_pkg::pit_chan_wr_t [pit_pkg::NUM_CHAN-1:0]      wr_o,
	output logic [pit_pkg::DATA_W-1:0]                         wdat_o,
	output pit_pkg::pit_ctrl_t [pit_pkg::NUM_CHAN-1:0]         ctrl_o,
	input  pit_pkg::pit_chan_stat_t [pit_pkg::NUM_CHAN-1:0]    stat_i
);

	// ========================================
	// select and ack
	// ========================================
	logic       sel;
	logic       wr_sel;
	logic       rd_sel;
	logic       rd_rdy;
	logic [1:0] chan_idx;
	logic [1:0] reg_idx;
	logic       chan_ok;

	// control word seen per byte lane
	pit_pkg::pit_ctrl_word_u    ctrl_wr;
	pit_pkg::pit_ctrl_word_u    ctrl_rd;
	logic [pit_pkg::DATA_W-1:0] rd_mux;

	assign sel    = req_i.cyc & req_i.stb & req_i.cs;
	assign wr_sel = sel & req_i.we;
	assign rd_sel = sel & ~req_i.we;

	// read data needs a cycle to register
	always_ff @(posedge clk_i) begin
		if (rst_i)
			rd_rdy <= 1'b0;
		else
			rd_rdy <= rd_sel;
	end

	// writes ack at once, reads on the second cycle of the select
	assign ack_o = wr_sel | (rd_sel & rd_rdy);

	// address fields
	assign chan_idx = req_i.adr[pit_pkg::CHAN_LSB +: 2];
	assign reg_idx  = req_i.adr[pit_pkg::REG_LSB +: 2];
	// channel 3 space is empty
	assign chan_ok  = (int'(chan_idx) < pit_pkg::NUM_CHAN);

	// ========================================
	// write side
	// ========================================
	assign wdat_o      = req_i.dat;
	assign ctrl_wr.raw = req_i.dat;

	always_comb begin
		for (int n = 0; n < pit_pkg::NUM_CHAN; n++) begin
			wr_o[n].wr_max = wr_sel && (chan_idx == 2'(n))
				&& (reg_idx == pit_pkg::REG_MAX);
			wr_o[n].wr_ont = wr_sel && (chan_idx == 2'(n))
				&& (reg_idx == pit_pkg::REG_ONT);
			// control write goes by byte select, not by channel address
			wr_o[n].wr_ctrl = wr_sel && (reg_idx == pit_pkg::REG_CTRL)
				&& req_i.sel[n];
			ctrl_o[n] = ctrl_wr.lane[n].ctrl;
		end
	end

	// ========================================
	// read side
	// ========================================
	// gather all channel controls into one word, ld always reads 0
	always_comb begin
		ctrl_rd.raw = '0;
		for (int n = 0; n < pit_pkg::NUM_CHAN; n++) begin
			ctrl_rd.lane[n].ctrl    = stat_i[n].ctrl;
			ctrl_rd.lane[n].ctrl.ld = 1'b0;
		end
	end

	always_comb begin
		rd_mux = '0;
		case (reg_idx)
			pit_pkg::REG_COUNT: begin
				if (chan_ok)
					rd_mux = stat_i[chan_idx].count;
			end
			pit_pkg::REG_MAX: begin
				if (chan_ok)
					rd_mux = stat_i[chan_idx].maxcount;
			end
			pit_pkg::REG_ONT: begin
				if (chan_ok)
					rd_mux = stat_i[chan_idx].ontime;
			end
			// same word from any channel address
			default: rd_mux = ctrl_rd.raw;
		endcase
	end

	// registered read data, valid while ack is high
	always_ff @(posedge clk_i) begin
		if (rd_sel)
			dat_o <= rd_mux;
	end

endmodule

/* design/pit_top.sv */
// interval timer top: bus slave plus three channels
module pit_top (
	input  logic                          clk_i,
	input  logic                          rst_i,
	// bus port
	input  logic                          cs_i,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [pit_pkg::SEL_W-1:0]     sel_i,
	input  logic [pit_pkg::ADR_W-1:0]     adr_i,
	input  logic [pit_pkg::DATA_W-1:0]    dat_i,
	output logic                          ack_o,
	output logic [pit_pkg::DATA_W-1:0]    dat_o,
	// timer pins, one bit per channel
	input  logic [pit_pkg::NUM_CHAN-1:0]  ext_clk_i,
	input  logic [pit_pkg::NUM_CHAN-1:0]  gate_i,
	output logic [pit_pkg::NUM_CHAN-1:0]  out_o
);

	// ========================================
	// internal wiring
	// ========================================
	pit_pkg::pit_bus_req_t                           req;
	pit_pkg::pit_chan_wr_t [pit_pkg::NUM_CHAN-1:0]   chan_wr;
	logic [pit_pkg::DATA_W-1:0]                      chan_wdat;
	pit_pkg::pit_ctrl_t [pit_pkg::NUM_CHAN-1:0]      chan_ctrl;
	pit_pkg::pit_chan_stat_t [pit_pkg::NUM_CHAN-1:0] chan_stat;

	// bundle the bus pins
	assign req.cs  = cs_i;
	assign req.cyc = cyc_i;
	assign req.stb = stb_i;
	assign req.we  = we_i;
	assign req.sel = sel_i;
	assign req.adr = adr_i;
	assign req.dat = dat_i;

	// register block
	pit_regs u_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (req),
		.ack_o  (ack_o),
		.dat_o  (dat_o),
		.wr_o   (chan_wr),
		.wdat_o (chan_wdat),
		.ctrl_o (chan_ctrl),
		.stat_i (chan_stat)
	);

	// ========================================
	// channels
	// ========================================
	for (genvar n = 0; n < pit_pkg::NUM_CHAN; n++) begin : g_chan
		pit_channel u_chan (
			.clk_i     (clk_i),
			.rst_i     (rst_i),
			.wr_i      (chan_wr[n]),
			.wdat_i    (chan_wdat),
			.ctrl_i    (chan_ctrl[n]),
			.ext_clk_i (ext_clk_i[n]),
			.gate_i    (gate_i[n]),
			.out_o     (out_o[n]),
			.stat_o    (chan_stat[n])
		);
	end

endmodule

/* dv/pit_tb.sv */
module pit_tb;

	// ========================================
	// data file op codes
	// ========================================
	localparam int          OP_MAX      = 64;
	localparam int          HALF_PER    = 10;
	localparam logic [31:0] OP_WRITE    = 32'h0;
	localparam logic [31:0] OP_READ     = 32'h1;
	localparam logic [31:0] OP_IDLE     = 32'h2;
	localparam logic [31:0] OP_GATE     = 32'h3;
	localparam logic [31:0] OP_PULSE    = 32'h4;
	localparam logic [31:0] OP_MEASURE  = 32'h5;
	localparam logic [31:0] OP_OUT_LVL  = 32'h6;
	localparam logic [31:0] OP_RISE     = 32'h7;
	localparam logic [31:0] OP_END      = 32'hff;

	logic                         clk_i;
	logic                         rst_i;
	logic                         cs_i;
	logic                         cyc_i;
	logic                         stb_i;
	logic                         we_i;
	logic [pit_pkg::SEL_W-1:0]    sel_i;
	logic [pit_pkg::ADR_W-1:0]    adr_i;
	logic [pit_pkg::DATA_W-1:0]   dat_i;
	logic                         ack_o;
	logic [pit_pkg::DATA_W-1:0]   dat_o;
	logic [pit_pkg::NUM_CHAN-1:0] ext_clk_i;
	logic [pit_pkg::NUM_CHAN-1:0] gate_i;
	logic [pit_pkg::NUM_CHAN-1:0] out_o;

	// four words per op for the code and three operands
	logic [31:0] ops [0:OP_MAX*4-1];
	int          error_count;
	int          check_count;
	int          cycle_count;
	int          cycle_limit;

	pit_top DUT (.*);

	initial begin
		clk_i = 1'b0;
		forever #(HALF_PER) clk_i = ~clk_i;
	end

	// ========================================
	// helpers
	// ========================================
	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
		end
	endtask

	// one bus cycle with the select held until ack shows at a falling edge
	task automatic bus_transfer(input logic wr, input logic [31:0] adr,
		input logic [31:0] sel, input logic [31:0] wdat, output logic [31:0] rdat);
		cs_i  = 1'b1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = wr;
		sel_i = sel[pit_pkg::SEL_W-1:0];
		adr_i = adr[pit_pkg::ADR_W-1:0];
		dat_i = wdat;
		@(negedge clk_i);
		while (ack_o !== 1'b1)
			@(negedge clk_i);
		rdat  = dat_o;
		cs_i  = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	// high time and rise to rise period of one out pin in clocks
	task automatic measure_out(input int ch, output int high_len, output int period);
		high_len = 0;
		period   = 0;
		// let a high phase in progress finish first
		while (out_o[ch] !== 1'b0)
			@(negedge clk_i);
		while (out_o[ch] !== 1'b1)
			@(negedge clk_i);
		while (out_o[ch] === 1'b1) begin
			high_len++;
			period++;
			@(negedge clk_i);
		end
		while (out_o[ch] === 1'b0) begin
			period++;
			@(negedge clk_i);
		end
	endtask

	// pulses three clocks wide with a random low gap of 3 to 6 clocks
	task automatic pulse_ext(input int ch, input int num);
		int gap;
		for (int i = 0; i < num; i++) begin
			gap = 3 + int'($urandom % 4);
			ext_clk_i[ch] = 1'b1;
			repeat (3) @(negedge clk_i);
			ext_clk_i[ch] = 1'b0;
			repeat (gap) @(negedge clk_i);
		end
	endtask

	// wait for all pins low and then for the first cycle with any pin high
	task automatic wait_rise(output logic [31:0] seen);
		while (out_o !== '0)
			@(negedge clk_i);
		while (out_o === '0)
			@(negedge clk_i);
		seen = 32'(out_o);
	endtask

	// ========================================
	// cycle limit
	// ========================================
	initial begin : watchdog
		cycle_count = 0;
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_i);
			cycle_count++;
		end
		error_count++;
		$display("run stopped at the cycle limit of %0d before all operations ran", cycle_limit);
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("Simulation failed");
		$finish;
	end

	// ========================================
	// main sequence
	// ========================================
	initial begin : main
		int          idx;
		int          limit;
		int          high_len;
		int          period;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] rdat;

		rst_i       = 1'b1;
		cs_i        = 1'b0;
		cyc_i       = 1'b0;
		stb_i       = 1'b0;
		we_i        = 1'b0;
		sel_i       = '0;
		adr_i       = '0;
		dat_i       = '0;
		ext_clk_i   = '0;
		gate_i      = '0;
		error_count = 0;
		check_count = 0;
		cycle_limit = 0;
		// seed once for the pulse gaps
		void'($urandom(81711));
		$readmemh("dv/pit_input.txt", ops);

		// first pass sums reset with a margin and 20 clocks per op
		limit = 40;
		idx   = 0;
		while (idx < OP_MAX && ops[4*idx] !== OP_END) begin
			case (ops[4*idx])
				OP_IDLE:    limit += int'(ops[4*idx+1]);
				OP_PULSE:   limit += 10 * int'(ops[4*idx+2]);
				OP_MEASURE: limit += 3 * int'(ops[4*idx+3]);
				default:    ;
			endcase
			limit += 20;
			idx++;
		end
		cycle_limit = limit;

		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		idx = 0;
		while (idx < OP_MAX && ops[4*idx] !== OP_END) begin
			op = ops[4*idx];
			a  = ops[4*idx+1];
			b  = ops[4*idx+2];
			c  = ops[4*idx+3];
			case (op)
				OP_WRITE: bus_transfer(1'b1, a, b, c, rdat);
				OP_READ: begin
					bus_transfer(1'b0, a, 32'h0, 32'h0, rdat);
					compare($sformatf("op %0d read adr 0x%02h", idx, a[7:0]), b, rdat);
				end
				OP_IDLE: begin
					// no select on the bus so no ack either
					repeat (a) begin
						@(negedge clk_i);
						compare($sformatf("op %0d ack while idle", idx), 32'h0,
							32'(ack_o));
					end
				end
				OP_GATE:  gate_i = a[pit_pkg::NUM_CHAN-1:0];
				OP_PULSE: pulse_ext(int'(a), int'(b));
				OP_MEASURE: begin
					measure_out(int'(a), high_len, period);
					compare($sformatf("op %0d out%0d high time", idx, a), b, 32'(high_len));
					compare($sformatf("op %0d out%0d period", idx, a), c, 32'(period));
				end
				OP_OUT_LVL: compare($sformatf("op %0d out pins", idx), a, 32'(out_o));
				OP_RISE: begin
					wait_rise(rdat);
					compare($sformatf("op %0d out pins at rise", idx), a, rdat);
				end
				default: begin
					error_count++;
					$display("unknown operation code %0h in data file entry %0d", op, idx);
				end
			endcase
			idx++;
		end

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/pit_input.txt */
// op a b c in hex; 0 write adr sel data, 1 read adr expected, 2 idle clocks, 3 gate mask,
// 4 pulses chan count, 5 measure chan high period, 6 out mask, 7 rise mask, ff end
0 04 f 12345678 // register readback
0 08 f cafe0001
1 04 12345678 0
1 08 cafe0001 0
0 0c 7 aaf00c15
2 2 0 0
1 1c 00100c14 0
0 04 f 0000000a // one-shot
0 08 f 00000003
0 0c 1 00000003
2 14 0 0
1 00 00000000 0
1 0c 00100c00 0
6 0 0 0
0 04 f 00000009 // pwm
0 0c 1 00000007
5 0 4 a
5 0 4 a
0 04 f 00000100 // gate
0 0c 1 00000013
2 2 0 0
1 00 00000100 0
2 5 0 0
1 00 00000100 0
3 1 0 0
2 a 0 0
1 00 000000f6 0
0 14 f 00000014 // external clock
0 1c 2 00000b00
2 2 0 0
4 1 5 0
2 8 0 0
1 10 0000000f 0
0 04 f 00000014 // synchronized start
0 24 f 00000014
0 08 f 00000000
0 2c 7 00070707
7 7 0 0
ff 0 0 0

/* files.f */
design/pit_pkg.sv
design/pit_edge_det.sv
design/pit_channel.sv
design/pit_regs.sv
design/pit_top.sv
dv/pit_tb.sv

/* Makefile */
TOP  := pit_tb
SRCS := $(shell cat files.f)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

obj_dir/V$(TOP): files.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
